//--- dma_bridge_top.f
hw/dma_bridge_pkg.sv
hw/dma_cmd_if.sv
hw/dma_rsp_if.sv
hw/dma_cmd_decode.sv
hw/dma_mem_execute.sv
hw/dma_result.sv
hw/dma_bridge_top.sv
verif/dma_bridge_tb.sv

//--- hw/dma_bridge_pkg.sv
// Shared types and widths for the disk DMA bridge
// Every bridge file refers to these through dma_bridge_pkg:: scoped names

package dma_bridge_pkg;

	//==================================================
	// Widths
	//==================================================
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	//==================================================
	// Command encoding
	//==================================================

	// One bit is enough, the host only reads or writes single words
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} dma_op_t;

	// Command as captured from the host, 66 bits
	// device is 1 for the hard disk and 0 for the floppy
	typedef struct packed {
		dma_op_t             op;
		logic                device;
		logic [ADDR_W-1:0]   addr;
		logic [DATA_W-1:0]   wdata;
	} dma_cmd_t;

endpackage

//--- hw/dma_bridge_top.sv
// Top level of the disk DMA bridge
// Host command port and Avalon memory port as plain ports, plus the two
// activity LEDs; LED_HOLD sets how long an LED stays lit after a transfer

`timescale 1ns/1ps

module dma_bridge_top #(
	parameter int LED_HOLD = 4500000
) (
	input  logic                                clk_sys,
	input  logic                                arst_n,

	// Host command port
	input  logic                                host_rd,
	input  logic                                host_wr,
	input  logic [dma_bridge_pkg::ADDR_W-1:0]   host_addr,
	input  logic [dma_bridge_pkg::DATA_W-1:0]   host_wdata,
	input  logic                                host_device,
	output logic                                host_wait,
	output logic [dma_bridge_pkg::DATA_W-1:0]   host_rdata,

	// Avalon memory port
	output logic                                mem_read,
	output logic                                mem_write,
	output logic [dma_bridge_pkg::ADDR_W-1:0]   mem_address,
	output logic [dma_bridge_pkg::DATA_W-1:0]   mem_writedata,
	input  logic                                mem_waitrequest,
	input  logic [dma_bridge_pkg::DATA_W-1:0]   mem_readdata,
	input  logic                                mem_readdatavalid,

	// Activity LEDs
	output logic                                led_hdd,
	output logic                                led_fdd
);

	dma_cmd_if cmd_if ();
	dma_rsp_if rsp_if ();

	dma_cmd_decode decode_i (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.host_rd     (host_rd),
		.host_wr     (host_wr),
		.host_addr   (host_addr),
		.host_wdata  (host_wdata),
		.host_device (host_device),
		.host_wait   (host_wait),
		.cmd         (cmd_if.decode)
	);

	dma_mem_execute execute_i (
		.clk_sys           (clk_sys),
		.arst_n            (arst_n),
		.mem_waitrequest   (mem_waitrequest),
		.mem_readdata      (mem_readdata),
		.mem_readdatavalid (mem_readdatavalid),
		.mem_read          (mem_read),
		.mem_write         (mem_write),
		.mem_address       (mem_address),
		.mem_writedata     (mem_writedata),
		.cmd               (cmd_if.execute),
		.rsp               (rsp_if.execute)
	);

	dma_result #(
		.LED_HOLD (LED_HOLD)
	) result_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.rsp        (rsp_if.result),
		.host_rdata (host_rdata),
		.led_hdd    (led_hdd),
		.led_fdd    (led_fdd)
	);

endmodule

//--- hw/dma_cmd_decode.sv
// Host command front end of the disk DMA bridge
// Turns a host read or write pulse into one pending command and holds
// the host off with host_wait until the memory side reports completion

`timescale 1ns/1ps

module dma_cmd_decode (
	input  logic                                clk_sys,
	input  logic                                arst_n,
	input  logic                                host_rd,
	input  logic                                host_wr,
	input  logic [dma_bridge_pkg::ADDR_W-1:0]   host_addr,
	input  logic [dma_bridge_pkg::DATA_W-1:0]   host_wdata,
	input  logic                                host_device,
	output logic                                host_wait,
	dma_cmd_if.decode                           cmd
);

	logic                     busy;
	logic                     accept;
	dma_bridge_pkg::dma_cmd_t cmd_q;

	// Pulses while busy are dropped here and nowhere else
	assign accept = !busy && (host_rd || host_wr);

	//==================================================
	// Pending flag
	//==================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
		end else if (cmd.cmd_done) begin
			busy <= 1'b0;
		end else if (accept) begin
			busy <= 1'b1;
		end
	end

	// Command payload, only loaded on an accepted pulse
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			// Both strobes at once counts as a read
			cmd_q.op     <= host_rd ? dma_bridge_pkg::OP_READ : dma_bridge_pkg::OP_WRITE;
			cmd_q.device <= host_device;
			cmd_q.addr   <= host_addr;
			cmd_q.wdata  <= host_wdata;
		end
	end

	// Busy to the host and valid to execute are the same state
	assign host_wait     = busy;
	assign cmd.cmd_valid = busy;
	assign cmd.cmd       = cmd_q;

endmodule

//--- hw/dma_cmd_if.sv
// Command link from host decode to the memory execute stage
// Decode holds cmd_valid and cmd steady until execute pulses cmd_done

`timescale 1ns/1ps

interface dma_cmd_if;

	// Decode side
	logic                     cmd_valid;
	dma_bridge_pkg::dma_cmd_t cmd;

	// One-cycle pulse when the bus transfer has finished
	logic                     cmd_done;

	modport decode (
		output cmd_valid,
		output cmd,
		input  cmd_done
	);

	modport execute (
		input  cmd_valid,
		input  cmd,
		output cmd_done
	);

endinterface

//--- hw/dma_mem_execute.sv
// Memory side of the disk DMA bridge
// Runs one Avalon single-word read or write per command, holding the
// request through waitrequest, then reports completion to decode and result

`timescale 1ns/1ps

module dma_mem_execute (
	input  logic                                clk_sys,
	input  logic                                arst_n,
	input  logic                                mem_waitrequest,
	input  logic [dma_bridge_pkg::DATA_W-1:0]   mem_readdata,
	input  logic                                mem_readdatavalid,
	output logic                                mem_read,
	output logic                                mem_write,
	output logic [dma_bridge_pkg::ADDR_W-1:0]   mem_address,
	output logic [dma_bridge_pkg::DATA_W-1:0]   mem_writedata,
	dma_cmd_if.execute                          cmd,
	dma_rsp_if.execute                          rsp
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_RWAIT
	} state_t;

	state_t                              state;
	logic                                start;
	logic                                accepted;
	logic                                done_q;
	dma_bridge_pkg::dma_op_t             op_q;
	logic                                device_q;
	logic [dma_bridge_pkg::ADDR_W-1:0]   addr_q;
	logic [dma_bridge_pkg::DATA_W-1:0]   wdata_q;
	logic [dma_bridge_pkg::DATA_W-1:0]   rdata_q;

	// cmd_valid is still high in the cycle of the done pulse,
	// so that cycle must not start the same command again
	assign start    = (state == ST_IDLE) && cmd.cmd_valid && !done_q;
	assign accepted = (state == ST_REQ) && !mem_waitrequest;

	//==================================================
	// Transfer FSM
	//==================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			mem_read  <= 1'b0;
			mem_write <= 1'b0;
			done_q    <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						mem_read  <= (cmd.cmd.op == dma_bridge_pkg::OP_READ);
						mem_write <= (cmd.cmd.op == dma_bridge_pkg::OP_WRITE);
						state     <= ST_REQ;
					end
				end
				ST_REQ: begin
					if (accepted) begin
						mem_read  <= 1'b0;
						mem_write <= 1'b0;
						// A write is finished once the slave takes it
						if (op_q == dma_bridge_pkg::OP_WRITE) begin
							done_q <= 1'b1;
							state  <= ST_IDLE;
						end else begin
							state  <= ST_RWAIT;
						end
					end
				end
				ST_RWAIT: begin
					if (mem_readdatavalid) begin
						done_q <= 1'b1;
						state  <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Request payload stays fixed from start to acceptance
	always_ff @(posedge clk_sys) begin
		if (start) begin
			op_q     <= cmd.cmd.op;
			device_q <= cmd.cmd.device;
			addr_q   <= cmd.cmd.addr;
			wdata_q  <= cmd.cmd.wdata;
		end
		if ((state == ST_RWAIT) && mem_readdatavalid) begin
			rdata_q <= mem_readdata;
		end
	end

	assign mem_address    = addr_q;
	assign mem_writedata  = wdata_q;

	// Completion goes to both decode and result in the same cycle
	assign cmd.cmd_done   = done_q;
	assign rsp.rsp_valid  = done_q;
	assign rsp.rsp_op     = op_q;
	assign rsp.rsp_device = device_q;
	assign rsp.rsp_rdata  = rdata_q;

endmodule

//--- hw/dma_result.sv
// Result stage of the disk DMA bridge
// Hands read data back to the host and keeps the hard disk and floppy
// activity LEDs lit for LED_HOLD cycles after each transfer of that device

`timescale 1ns/1ps

module dma_result #(
	parameter int LED_HOLD = 4500000
) (
	input  logic                                clk_sys,
	input  logic                                arst_n,
	dma_rsp_if.result                           rsp,
	output logic [dma_bridge_pkg::DATA_W-1:0]   host_rdata,
	output logic                                led_hdd,
	output logic                                led_fdd
);

	localparam int CNT_W = $clog2(LED_HOLD + 1);

	// Index 1 is the hard disk, 0 the floppy, same as rsp_device
	logic [CNT_W-1:0] led_cnt [2];

	//==================================================
	// Read data back to the host
	//==================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			host_rdata <= '0;
		end else if (rsp.rsp_valid && (rsp.rsp_op == dma_bridge_pkg::OP_READ)) begin
			host_rdata <= rsp.rsp_rdata;
		end
		// Writes keep the last read word
	end

	//==================================================
	// Activity LED stretch
	//==================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 2; i++) begin
				led_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (rsp.rsp_valid && (rsp.rsp_device == 1'(i))) begin
					// Each new transfer restarts the hold time
					led_cnt[i] <= CNT_W'(LED_HOLD);
				end else if (led_cnt[i] != '0) begin
					led_cnt[i] <= led_cnt[i] - 1'b1;
				end
			end
		end
	end

	assign led_hdd = (led_cnt[1] != '0);
	assign led_fdd = (led_cnt[0] != '0);

endmodule

//--- hw/dma_rsp_if.sv
// Response link from the memory execute stage to the result stage
// No back-pressure here, result takes every rsp_valid pulse

`timescale 1ns/1ps

interface dma_rsp_if;

	logic                                rsp_valid;
	dma_bridge_pkg::dma_op_t             rsp_op;
	logic                                rsp_device;
	logic [dma_bridge_pkg::DATA_W-1:0]   rsp_rdata;

	modport execute (
		output rsp_valid,
		output rsp_op,
		output rsp_device,
		output rsp_rdata
	);

	modport result (
		input  rsp_valid,
		input  rsp_op,
		input  rsp_device,
		input  rsp_rdata
	);

endinterface

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the disk DMA bridge testbench with Verilator and runs it.
# The result is taken from the simulation log.

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=Vdma_bridge_tb

verilator --binary --timing --assert -Wno-fatal \
	-Mdir obj_dir --top-module dma_bridge_tb \
	-f dma_bridge_top.f -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

echo "Simulation passed"
exit 0

//--- verif/dma_bridge_tb.sv
// Testbench for the disk DMA bridge
// Random host reads and writes run against an Avalon memory model with random
// wait states and read latency, and are checked against a reference model

`timescale 1ns/1ps

module dma_bridge_tb;

	localparam int LED_HOLD        = 40;
	localparam int NUM_CMDS        = 300;
	localparam int WATCHDOG_CYCLES = NUM_CMDS * 400 + 1000;

	logic                                clk_sys = 1'b0;
	logic                                arst_n;
	logic                                host_rd;
	logic                                host_wr;
	logic [dma_bridge_pkg::ADDR_W-1:0]   host_addr;
	logic [dma_bridge_pkg::DATA_W-1:0]   host_wdata;
	logic                                host_device;
	logic                                host_wait;
	logic [dma_bridge_pkg::DATA_W-1:0]   host_rdata;
	logic                                mem_read;
	logic                                mem_write;
	logic [dma_bridge_pkg::ADDR_W-1:0]   mem_address;
	logic [dma_bridge_pkg::DATA_W-1:0]   mem_writedata;
	logic                                mem_waitrequest = 1'b0;
	logic [dma_bridge_pkg::DATA_W-1:0]   mem_readdata = '0;
	logic                                mem_readdatavalid = 1'b0;
	logic                                led_hdd;
	logic                                led_fdd;

	// Memory model, reference model and bus request log
	logic [31:0] mem_model [256];
	logic [31:0] ref_mem [256];
	int          acc_count;
	logic        acc_is_write;
	logic [31:0] acc_addr;
	logic [31:0] acc_wdata;
	logic        rd_pending;
	int          rd_delay;
	logic [7:0]  rd_idx;
	logic        prev_read = 1'b0;
	logic        prev_write = 1'b0;
	logic        prev_wait = 1'b0;
	logic [31:0] prev_addr;
	logic [31:0] prev_wdata;
	logic        cur_device = 1'b0;
	int          led_model [2];
	logic        wait_seen;

	always #10 clk_sys = ~clk_sys;

	dma_bridge_top #(
		.LED_HOLD (LED_HOLD)
	) dut_i (.*);

	task automatic halt_failed();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic value_error(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("FAILED %s: got %h, expected %h", name, got, expected);
		halt_failed();
	endtask

	// Initial memory contents differ for every word address
	function automatic logic [31:0] fill_word(input int i);
		return {8'(i), 8'(~i), 8'(i * 7), 8'(i ^ 8'h5a)};
	endfunction

	task automatic check_reset_outputs();
		assert (!host_wait) else value_error("host_wait", host_wait, 1'b0);
		assert (!mem_read) else value_error("mem_read", mem_read, 1'b0);
		assert (!mem_write) else value_error("mem_write", mem_write, 1'b0);
		assert (!led_hdd) else value_error("led_hdd", led_hdd, 1'b0);
		assert (!led_fdd) else value_error("led_fdd", led_fdd, 1'b0);
		assert (host_rdata == '0) else value_error("host_rdata", host_rdata, 32'h0);
	endtask

	//==================================================
	// Avalon memory model
	//==================================================
	always @(posedge clk_sys) begin
		if (!arst_n) begin
			for (int i = 0; i < 256; i++) begin
				mem_model[i] <= fill_word(i);
			end
			mem_waitrequest   <= 1'b0;
			mem_readdatavalid <= 1'b0;
			rd_pending        <= 1'b0;
			rd_delay          <= 0;
			acc_count         <= 0;
		end else begin
			mem_waitrequest   <= ($urandom % 3 == 0);
			mem_readdatavalid <= 1'b0;
			if ((mem_read || mem_write) && !mem_waitrequest) begin
				acc_count    <= acc_count + 1;
				acc_is_write <= mem_write;
				acc_addr     <= mem_address;
				acc_wdata    <= mem_writedata;
				if (mem_write) begin
					mem_model[mem_address[9:2]] <= mem_writedata;
				end else begin
					rd_pending <= 1'b1;
					rd_delay   <= 1 + int'($urandom % 4);
					rd_idx     <= mem_address[9:2];
				end
			end else if (rd_pending) begin
				if (rd_delay == 1) begin
					mem_readdatavalid <= 1'b1;
					mem_readdata      <= mem_model[rd_idx];
					rd_pending        <= 1'b0;
				end else begin
					rd_delay <= rd_delay - 1;
				end
			end
		end
	end

	// Bus rules checked on the values the DUT had before this edge
	always @(posedge clk_sys) begin
		if (arst_n) begin
			assert (!(mem_read && mem_write)) else begin
				$display("ERROR: mem_read and mem_write are high together");
				halt_failed();
			end
			if ((prev_read || prev_write) && prev_wait) begin
				assert (mem_read == prev_read)
					else value_error("mem_read", mem_read, prev_read);
				assert (mem_write == prev_write)
					else value_error("mem_write", mem_write, prev_write);
				assert (mem_address == prev_addr)
					else value_error("mem_address", mem_address, prev_addr);
				assert (mem_writedata == prev_wdata)
					else value_error("mem_writedata", mem_writedata, prev_wdata);
			end
		end
		prev_read  <= mem_read;
		prev_write <= mem_write;
		prev_wait  <= mem_waitrequest;
		prev_addr  <= mem_address;
		prev_wdata <= mem_writedata;
	end

	// LED prediction reloads on each fall of host_wait for the command's device
	always @(negedge clk_sys) begin
		if (!arst_n) begin
			led_model[0] = 0;
			led_model[1] = 0;
			wait_seen    = 1'b0;
		end else begin
			for (int d = 0; d < 2; d++) begin
				if (led_model[d] != 0) begin
					led_model[d] = led_model[d] - 1;
				end
			end
			if (wait_seen && !host_wait) begin
				led_model[cur_device] = LED_HOLD;
			end
			wait_seen = host_wait;
			assert (led_hdd == (led_model[1] != 0))
				else value_error("led_hdd", led_hdd, led_model[1] != 0);
			assert (led_fdd == (led_model[0] != 0))
				else value_error("led_fdd", led_fdd, led_model[0] != 0);
		end
	end

	//==================================================
	// Host side
	//==================================================
	// Starts and returns on a falling edge
	// Extra pulses go in only while a strobe is up, when the bridge is
	// certain to still be busy at the edge that samples them
	task automatic do_command(input logic is_read, input logic [31:0] addr,
		input logic [31:0] wdata, input logic device);
		int          base;
		logic        both;
		logic        finished;
		logic        inject;
		logic [31:0] inj_word;
		logic [7:0]  idx;
		base     = acc_count;
		both     = ($urandom % 8 == 0);
		finished = 1'b0;
		inject   = 1'b0;
		inj_word = 32'h0;
		idx      = addr[9:2];
		@(posedge clk_sys);
		cur_device  = device;
		host_rd     <= is_read;
		host_wr     <= !is_read || both;
		host_addr   <= addr;
		host_wdata  <= wdata;
		host_device <= device;
		while (!finished) begin
			@(posedge clk_sys);
			host_rd <= 1'b0;
			host_wr <= 1'b0;
			if (inject) begin
				host_rd     <= inj_word[0];
				host_wr     <= 1'b1;
				host_addr   <= inj_word ^ 32'h0000_0ff0;
				host_wdata  <= ~inj_word;
				host_device <= ~device;
			end
			@(negedge clk_sys);
			finished = !host_wait;
			inject   = host_wait && (mem_read || mem_write) && ($urandom % 4 == 0);
			inj_word = $urandom;
		end
		assert (acc_count == base + 1) else begin
			$display("ERROR: command at address %h made %0d bus requests instead of one",
				addr, acc_count - base);
			halt_failed();
		end
		assert (acc_is_write == !is_read)
			else value_error("mem_write", acc_is_write, !is_read);
		assert (acc_addr == addr) else value_error("mem_address", acc_addr, addr);
		if (is_read) begin
			assert (host_rdata == ref_mem[idx])
				else value_error("host_rdata", host_rdata, ref_mem[idx]);
		end else begin
			assert (acc_wdata == wdata) else value_error("mem_writedata", acc_wdata, wdata);
			ref_mem[idx] = wdata;
		end
		if (device) begin
			assert (led_hdd) else value_error("led_hdd", led_hdd, 1'b1);
		end else begin
			assert (led_fdd) else value_error("led_fdd", led_fdd, 1'b1);
		end
	endtask

	initial begin
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        is_read;
		logic        device;
		void'($urandom(32'h700b));
		for (int i = 0; i < 256; i++) begin
			ref_mem[i] = fill_word(i);
		end
		arst_n      <= 1'b0;
		host_rd     <= 1'b0;
		host_wr     <= 1'b0;
		host_addr   <= '0;
		host_wdata  <= '0;
		host_device <= 1'b0;
		repeat (5) begin
			@(negedge clk_sys);
			check_reset_outputs();
		end
		@(posedge clk_sys);
		arst_n <= 1'b1;
		@(negedge clk_sys);
		check_reset_outputs();

		for (int n = 0; n < NUM_CMDS; n++) begin
			is_read = 1'($urandom);
			addr    = {$urandom} & 32'hffff_fffc;
			wdata   = $urandom;
			device  = 1'($urandom);
			do_command(is_read, addr, wdata, device);
		end

		// With the bus quiet both LEDs go dark
		repeat (LED_HOLD + 2) @(negedge clk_sys);
		assert (!led_hdd) else value_error("led_hdd", led_hdd, 1'b0);
		assert (!led_fdd) else value_error("led_fdd", led_fdd, 1'b0);
		$display("NO ERRORS");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("ERROR: watchdog timeout, the test did not end within %0d cycles",
			WATCHDOG_CYCLES);
		halt_failed();
	end

endmodule
